/* src.f */
+incdir+src
src/heapPkg.sv
src/heapAllocator.sv
src/heapSizeTable.sv
src/elementStore.sv
src/heapControl.sv
src/heapTop.sv
dv/heapTb.sv

/* dv/heapTb.sv */
//--------------------------------------------------
// Array heap testbench
// Directed and random actions against a model heap
//--------------------------------------------------
`default_nettype none
`include "heap_macros.svh"

module heapTb import heapPkg::*; ();

  localparam int directedActions = 100;               // Directed steps below, rounded up
  localparam int randomActions   = 400;
  localparam int cycleLimit      = 5 + directedActions + randomActions + 20;

  logic clock, resetN;
  heapActionT action;
  logic [`HEAP_ADDRESS_BITS-1:0] array;
  logic [`HEAP_INDEX_BITS-1:0] index;
  logic [`HEAP_DATA_BITS-1:0] dataIn;
  heapWordT dataOut;
  heapErrorT error;

  logic [18:0] expWord, heldWord;                     // {error, dataOut}
  logic expValid, heldValid;
  integer seed;
  int cycleCount, a, i, n;
  logic [31:0] pick;

  // Model heap state
  int modelCount, modelTop;
  int modelStack [`HEAP_ARRAYS];
  int modelSize [`HEAP_ARRAYS];
  logic modelLive [`HEAP_ARRAYS];
  logic [`HEAP_DATA_BITS-1:0] modelMem [`HEAP_ARRAYS][`HEAP_ARRAY_LENGTH];
  logic [`HEAP_DATA_BITS-1:0] modelOut;
  heapErrorT modelErr;

  heapActionT randomCodes [21] = '{actIdle, actWrite, actRead, actSize, actInc, actDec,
    actPush, actPop, actAlloc, actFree, actAdd, actAddAfter, actSubtract, actSubAfter,
    actShiftLeft, actShiftRight, actNotLogical, actNot, actOr, actXor, actAnd};

  heapTop i_dut (
    .clock, .resetN, .action, .array, .index, .dataIn, .dataOut, .error
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;                       // Period 20
  end

  // --------------------------------------------------
  // Reference model stepping one action per call
  // --------------------------------------------------
  function automatic logic [18:0] referenceStep(heapActionT act, logic [1:0] arr,
                                                logic [2:0] idx, logic [15:0] din);
    heapErrorT err;
    logic [15:0] old, newVal;
    int handle;
    err = errNone;
    old = modelMem[arr][idx];
    if (act == actIdle) return {modelErr, modelOut};   // Nothing moves
    if (act == actReset || act == actAlloc) err = errNone;
    else if (arr >= modelCount) err = errNeverAllocated;
    else if (!modelLive[arr]) err = errFreed;
    else if ((act == actRead || act >= actAdd) && idx >= modelSize[arr]) err = errOutOfBounds;
    else if ((act == actDec || act == actPop) && modelSize[arr] == 0) err = errEmpty;
    else if ((act == actInc || act == actPush) && modelSize[arr] == `HEAP_ARRAY_LENGTH)
      err = errFull;
    if (act == actAlloc && modelTop == 0 && modelCount == `HEAP_ARRAYS) err = errOutOfMemory;
    modelErr = err;
    if (err != errNone) return {modelErr, modelOut};   // Output held on error
    case (act)
      actReset: begin
        modelCount = 0;
        modelTop = 0;
        for (int k = 0; k < `HEAP_ARRAYS; k++) begin
          modelLive[k] = 1'b0;
          modelSize[k] = 0;
        end
      end
      actWrite: begin
        modelMem[arr][idx] = din;
        if (idx + 1 > modelSize[arr]) modelSize[arr] = idx + 1;   // Grows only
        modelOut = din;
      end
      actRead: modelOut = old;
      actSize: modelOut = modelSize[arr];
      actInc:  modelSize[arr]++;
      actDec:  modelSize[arr]--;
      actPush: begin
        modelMem[arr][modelSize[arr]] = din;
        modelSize[arr]++;
      end
      actPop: begin
        modelSize[arr]--;
        modelOut = modelMem[arr][modelSize[arr]];     // Last in, first out
      end
      actAlloc: begin
        if (modelTop > 0) begin
          modelTop--;
          handle = modelStack[modelTop];              // Most recently freed
        end else begin
          handle = modelCount;
          modelCount++;
        end
        modelLive[handle] = 1'b1;
        modelSize[handle] = 0;
        modelOut = handle;
      end
      actFree: begin
        modelStack[modelTop] = arr;
        modelTop++;
        modelLive[arr] = 1'b0;
      end
      default: begin                                  // Element updates
        case (act)
          actAdd, actAddAfter:      newVal = old + din;
          actSubtract, actSubAfter: newVal = old - din;
          actShiftLeft:  newVal = old << din;
          actShiftRight: newVal = old >> din;
          actNotLogical: newVal = (old == 0) ? 16'd1 : 16'd0;
          actNot:        newVal = ~old;
          actOr:         newVal = old | din;
          actXor:        newVal = old ^ din;
          default:       newVal = old & din;
        endcase
        modelMem[arr][idx] = newVal;
        modelOut = (act == actAddAfter || act == actSubAfter) ? old : newVal;
      end
    endcase
    return {modelErr, modelOut};
  endfunction

  task automatic compareValue(string name, logic [15:0] got, logic [15:0] want);
    if (got !== want) begin
      $display("MISMATCH %s: got %h, expected %h", name, got, want);
      $display("Simulation finished: FAIL");
      $fatal(1, "Output check failed");
    end
  endtask

  // One action per cycle, driven just after the edge
  task automatic applyAction(heapActionT act, logic [1:0] arr, logic [2:0] idx,
                             logic [15:0] din);
    @(posedge clock);
    #2;
    action = act;
    array = arr;
    index = idx;
    dataIn = din;
    expWord = referenceStep(act, arr, idx, din);
    expValid = 1'b1;
  endtask

  // --------------------------------------------------
  // Compare process and watchdog
  // --------------------------------------------------
  initial begin
    forever begin
      @(posedge clock);
      heldWord = expWord;                             // Action sampled at this edge
      heldValid = expValid;
      #5;
      if (heldValid) begin
        compareValue("dataOut", dataOut, heldWord[15:0]);
        compareValue("error", 16'(error), 16'(heldWord[18:16]));
      end
    end
  end

  always @(posedge clock) begin
    cycleCount++;
    if (cycleCount > cycleLimit) begin
      $display("Timeout: run did not finish within %0d cycles", cycleLimit);
      $display("Simulation finished: FAIL");
      $fatal(1, "Timeout");
    end
  end

  initial begin
    seed = 32'h6252f135;
    cycleCount = 0;
    resetN = 1'b0;
    action = actIdle;
    array = '0;
    index = '0;
    dataIn = '0;
    expWord = '0;
    expValid = 1'b0;
    modelOut = '0;
    modelErr = errNone;
    void'(referenceStep(actReset, 0, 0, 0));          // Model matches reset state
    repeat (5) @(posedge clock);
    #2 resetN = 1'b1;
    // Never-allocated array checks before all four handles
    applyAction(actReset, 0, 0, 0);
    applyAction(actRead, 3, 0, 0);
    applyAction(actSize, 3, 0, 0);
    applyAction(actFree, 3, 0, 0);
    for (n = 0; n < 5; n++) applyAction(actAlloc, 0, 0, 0);   // Fifth is out of memory
    // Fill every element so later reads are known
    for (a = 0; a < `HEAP_ARRAYS; a++) begin
      for (i = 0; i < `HEAP_ARRAY_LENGTH; i++) begin
        pick = $random(seed);
        applyAction(actWrite, a, i, pick[15:0]);
      end
      applyAction(actRead, a, a + 2, 0);
      applyAction(actSize, a, 0, 0);
    end
    // Size limits on array 0
    for (n = 0; n < 9; n++) applyAction(actDec, 0, 0, 0);
    for (n = 0; n < 9; n++) applyAction(actInc, 0, 0, 0);
    for (n = 0; n < 5; n++) applyAction(actDec, 0, 0, 0);
    applyAction(actRead, 0, 5, 0);                    // Past size 3
    // Free and reuse
    applyAction(actFree, 1, 0, 0);
    applyAction(actFree, 2, 0, 0);
    applyAction(actRead, 1, 0, 0);
    applyAction(actFree, 1, 0, 0);
    applyAction(actAlloc, 0, 0, 0);                   // Expect 2
    applyAction(actAlloc, 0, 0, 0);                   // Expect 1
    // Stack behaviour on array 1
    applyAction(actPop, 1, 0, 0);
    for (n = 0; n < 9; n++) applyAction(actPush, 1, 0, 16'h1000 + n);
    for (n = 0; n < 9; n++) applyAction(actPop, 1, 0, 0);
    // --------------------------------------------------
    // Random mix
    // --------------------------------------------------
    for (n = 0; n < randomActions; n++) begin
      pick = $random(seed);
      if (pick[29:24] == 0) applyAction(actReset, 0, 0, 0);   // Rare heap clear
      else if (pick[31]) applyAction(actAlloc, 0, 0, 0);
      else applyAction(randomCodes[pick[23:16] % 21], pick[1:0], pick[4:2],
                       pick[5] ? {12'h0, pick[9:6]} : $random(seed));   // Small shifts too
    end
    applyAction(actIdle, 0, 0, 0);
    repeat (2) @(posedge clock);
    #8;
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* src/heapTop.sv */
//--------------------------------------------------
// Array heap
// Command port over allocator, sizes and elements
//--------------------------------------------------
`default_nettype none
`include "heap_macros.svh"

module heapTop import heapPkg::*; (
  input  wire                          clock,
  input  wire                          resetN,
  input  wire heapActionT              action,     // Zero is idle
  input  wire [`HEAP_ADDRESS_BITS-1:0] array,
  input  wire [`HEAP_INDEX_BITS-1:0]   index,
  input  wire [`HEAP_DATA_BITS-1:0]    dataIn,
  output heapWordT                     dataOut,    // Registered result
  output heapErrorT                    error
);

  logic                          allocate, free, clearAll, writeEnable;
  logic                          arrayLive, everAllocated, canAllocate;
  logic [`HEAP_ADDRESS_BITS-1:0] nextHandle;
  logic [`HEAP_SIZE_BITS-1:0]    currentSize, targetSize;
  logic [`HEAP_INDEX_BITS-1:0]   elementIndex;
  logic [`HEAP_DATA_BITS-1:0]    oldValue, newValue;
  heapSizeOpT                    sizeOp;
  heapUpdateT                    updateSel;

  heapControl u_control (
    .clock, .resetN, .action, .array, .index,
    .arrayLive, .everAllocated, .canAllocate, .nextHandle, .currentSize,
    .oldValue, .newValue,
    .allocate, .free, .clearAll, .sizeOp, .targetSize, .elementIndex,
    .updateSel, .writeEnable, .dataOut, .error
  );

  heapAllocator u_allocator (
    .clock, .resetN, .array, .allocate, .free, .clearAll,
    .arrayLive, .everAllocated, .canAllocate, .nextHandle
  );

  heapSizeTable u_sizeTable (
    .clock, .resetN, .array, .sizeOp, .targetSize, .nextHandle,
    .currentSize
  );

  elementStore u_elements (
    .clock, .array, .elementIndex, .dataIn, .updateSel, .writeEnable,
    .oldValue, .newValue
  );

endmodule

`default_nettype wire

/* src/heapControl.sv */
//--------------------------------------------------
// Heap controller
// Decodes actions, checks access, drives the
// strobes and registers result and error
//--------------------------------------------------
`default_nettype none
`include "heap_macros.svh"

module heapControl import heapPkg::*; (
  input  wire                           clock,
  input  wire                           resetN,
  input  wire heapActionT               action,
  input  wire [`HEAP_ADDRESS_BITS-1:0]  array,
  input  wire [`HEAP_INDEX_BITS-1:0]    index,
  input  wire                           arrayLive,
  input  wire                           everAllocated,
  input  wire                           canAllocate,
  input  wire [`HEAP_ADDRESS_BITS-1:0]  nextHandle,
  input  wire [`HEAP_SIZE_BITS-1:0]     currentSize,
  input  wire [`HEAP_DATA_BITS-1:0]     oldValue,
  input  wire [`HEAP_DATA_BITS-1:0]     newValue,
  output logic                          allocate,
  output logic                          free,
  output logic                          clearAll,
  output heapSizeOpT                    sizeOp,
  output logic [`HEAP_SIZE_BITS-1:0]    targetSize,
  output logic [`HEAP_INDEX_BITS-1:0]   elementIndex,
  output heapUpdateT                    updateSel,
  output logic                          writeEnable,
  output heapWordT                      dataOut,
  output heapErrorT                     error
);

  logic known, checkArray, checkBounds, needData, needRoom, isUpdate, actionOk;
  logic inBounds, isEmpty, isFull;
  logic [`HEAP_SIZE_BITS-1:0] lastSlot;               // Size minus one for pop
  heapErrorT nextError;
  heapWordT  resultWord;

  assign inBounds = ({1'b0, index} < currentSize);
  assign isEmpty  = (currentSize == '0);
  assign isFull   = (currentSize == `HEAP_ARRAY_LENGTH);
  assign lastSlot = currentSize - 1'b1;

  // --------------------------------------------------
  // Action classes
  // --------------------------------------------------
  always_comb begin
    {known, checkArray, checkBounds, needData, needRoom, isUpdate} = 6'b100000;
    updateSel = updPass;                             // Write and push store dataIn
    case (action)
      actReset, actAlloc: ;                          // No array checks
      actWrite, actSize, actFree: checkArray = 1'b1;
      actRead: {checkArray, checkBounds} = 2'b11;
      actInc, actPush: {checkArray, needRoom} = 2'b11;
      actDec, actPop:  {checkArray, needData} = 2'b11;
      actAdd, actAddAfter:     updateSel = updAdd;
      actSubtract, actSubAfter: updateSel = updSub;
      actShiftLeft:  updateSel = updShiftLeft;
      actShiftRight: updateSel = updShiftRight;
      actNotLogical: updateSel = updNotLogical;
      actNot:        updateSel = updNot;
      actOr:         updateSel = updOr;
      actXor:        updateSel = updXor;
      actAnd:        updateSel = updAnd;
      default: known = 1'b0;                         // Idle and unused codes
    endcase
    if (updateSel != updPass) {checkArray, checkBounds, isUpdate} = 3'b111;
  end

  // Checks in priority order
  always_comb begin
    nextError = errNone;
    if (checkArray && !everAllocated)            nextError = errNeverAllocated;
    else if (checkArray && !arrayLive)           nextError = errFreed;
    else if (checkBounds && !inBounds)           nextError = errOutOfBounds;
    else if (needData && isEmpty)                nextError = errEmpty;
    else if (needRoom && isFull)                 nextError = errFull;
    else if (action == actAlloc && !canAllocate) nextError = errOutOfMemory;
  end

  // --------------------------------------------------
  // Strobes stay quiet on error or idle
  // --------------------------------------------------
  assign actionOk    = known && (nextError == errNone);
  assign allocate    = actionOk && (action == actAlloc);
  assign free        = actionOk && (action == actFree);
  assign clearAll    = actionOk && (action == actReset);
  assign writeEnable = actionOk && (action == actWrite || action == actPush || isUpdate);
  assign targetSize  = {1'b0, index} + 1'b1;         // Write grows to index plus one

  always_comb begin
    case (action)
      actPush: elementIndex = currentSize[`HEAP_INDEX_BITS-1:0];   // First free slot
      actPop:  elementIndex = lastSlot[`HEAP_INDEX_BITS-1:0];
      default: elementIndex = index;
    endcase
  end

  always_comb begin
    sizeOp = sizeHold;
    if (actionOk) begin
      case (action)
        actReset:         sizeOp = sizeClearAll;
        actAlloc:         sizeOp = sizeClearHandle;
        actInc, actPush:  sizeOp = sizeInc;
        actDec, actPop:   sizeOp = sizeDec;
        actWrite:         sizeOp = sizeGrowTo;
        default: ;
      endcase
    end
  end

  // --------------------------------------------------
  // Result word and registers
  // --------------------------------------------------
  always_comb begin
    resultWord = dataOut;                            // Unchanged unless listed
    case (action)
      actRead, actPop, actAddAfter, actSubAfter: resultWord.element = oldValue;
      actSize: resultWord.element = {{(`HEAP_DATA_BITS-`HEAP_SIZE_BITS){1'b0}}, currentSize};
      actAlloc: begin
        resultWord.handleView.pad    = '0;
        resultWord.handleView.handle = nextHandle;
      end
      actInc, actDec, actPush, actFree, actReset: ;
      default: resultWord.element = newValue;        // Write and new-value updates
    endcase
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      dataOut <= '0;
      error   <= errNone;
    end else begin
      if (known)    error   <= nextError;            // Returns to none after a good one
      if (actionOk) dataOut <= resultWord;
    end
  end

  // Stores need a live array and a legal slot
  assert property (@(posedge clock) disable iff (!resetN)
                   writeEnable |-> everAllocated && arrayLive
                                   && (action != actPush || !isFull)
                                   && (!isUpdate || inBounds))
    else $error("Element written on an erroneous action");

endmodule

`default_nettype wire

/* src/elementStore.sv */
//--------------------------------------------------
// Element store
// Element memory with a read-modify-write ALU
//--------------------------------------------------
`default_nettype none
`include "heap_macros.svh"

module elementStore import heapPkg::*; (
  input  wire                          clock,
  input  wire [`HEAP_ADDRESS_BITS-1:0] array,          // Array number
  input  wire [`HEAP_INDEX_BITS-1:0]   elementIndex,   // Element within array
  input  wire [`HEAP_DATA_BITS-1:0]    dataIn,         // Operand or value to store
  input  wire heapUpdateT              updateSel,      // ALU function
  input  wire                          writeEnable,    // Store newValue at the edge
  output logic [`HEAP_DATA_BITS-1:0]   oldValue,       // Current contents
  output logic [`HEAP_DATA_BITS-1:0]   newValue        // Contents after update
);

  // Arrays laid out in fixed blocks
  logic [`HEAP_DATA_BITS-1:0] memory [`HEAP_ARRAYS][`HEAP_ARRAY_LENGTH];

  logic notLogical;                                    // High when element is zero

  // --------------------------------------------------
  // Combinational read
  // --------------------------------------------------
  assign oldValue   = memory[array][elementIndex];
  assign notLogical = ~|oldValue;

  // --------------------------------------------------
  // Update ALU
  // --------------------------------------------------
  always_comb begin
    case (updateSel)
      updPass:       newValue = dataIn;             // Write and push
      updAdd:        newValue = oldValue + dataIn;  // Wraps at data width
      updSub:        newValue = oldValue - dataIn;
      updShiftLeft:  newValue = oldValue << dataIn;
      updShiftRight: newValue = oldValue >> dataIn;
      updNotLogical: newValue = {{(`HEAP_DATA_BITS-1){1'b0}}, notLogical};
      updNot:        newValue = ~oldValue;
      updOr:         newValue = oldValue | dataIn;
      updXor:        newValue = oldValue ^ dataIn;
      updAnd:        newValue = oldValue & dataIn;
      default:       newValue = dataIn;
    endcase
  end

  // --------------------------------------------------
  // Write port
  // --------------------------------------------------
  always_ff @(posedge clock) begin
    if (writeEnable) begin
      memory[array][elementIndex] <= newValue;      // Same edge as the action
    end
  end

endmodule

`default_nettype wire

/* src/heapSizeTable.sv */
//--------------------------------------------------
// Heap size table
// Current element count of every array
//--------------------------------------------------
`default_nettype none
`include "heap_macros.svh"

module heapSizeTable import heapPkg::*; (
  input  wire                           clock,
  input  wire                           resetN,
  input  wire [`HEAP_ADDRESS_BITS-1:0]  array,        // Addressed array
  input  wire heapSizeOpT               sizeOp,       // Update command
  input  wire [`HEAP_SIZE_BITS-1:0]     targetSize,   // Used by growTo
  input  wire [`HEAP_ADDRESS_BITS-1:0]  nextHandle,   // Array being handed out
  output logic [`HEAP_SIZE_BITS-1:0]    currentSize
);

  logic [`HEAP_SIZE_BITS-1:0] sizes [`HEAP_ARRAYS];   // One size per array

  assign currentSize = sizes[array];

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int i = 0; i < `HEAP_ARRAYS; i++) sizes[i] <= '0;
    end else begin
      case (sizeOp)
        sizeClearAll: for (int i = 0; i < `HEAP_ARRAYS; i++) sizes[i] <= '0;
        sizeClearHandle: sizes[nextHandle] <= '0;          // New array starts empty
        sizeInc:         sizes[array] <= currentSize + 1'b1;
        sizeDec:         sizes[array] <= currentSize - 1'b1;
        sizeGrowTo: begin
          if (targetSize > currentSize) sizes[array] <= targetSize;   // Never shrinks
        end
        default: ;                                     // Hold
      endcase
    end
  end

  // Full and empty checks live in the controller
  for (genvar g = 0; g < `HEAP_ARRAYS; g++) begin : gSizeCheck
    assert property (@(posedge clock) disable iff (!resetN)
                     sizes[g] <= `HEAP_ARRAY_LENGTH)
      else $error("Array %0d size past array length", g);
  end

endmodule

`default_nettype wire

/* src/heapAllocator.sv */
//--------------------------------------------------
// Heap allocator
// LIFO stack of freed arrays, live flags and the
// high-water count of arrays handed out
//--------------------------------------------------
`default_nettype none
`include "heap_macros.svh"

module heapAllocator (
  input  wire                          clock,
  input  wire                          resetN,
  input  wire [`HEAP_ADDRESS_BITS-1:0] array,          // Addressed array
  input  wire                          allocate,       // Hand out nextHandle
  input  wire                          free,           // Return array to stack
  input  wire                          clearAll,       // Empty the heap
  output logic                         arrayLive,
  output logic                         everAllocated,
  output logic                         canAllocate,
  output logic [`HEAP_ADDRESS_BITS-1:0] nextHandle
);

  logic [`HEAP_ADDRESS_BITS-1:0] freeStack [`HEAP_ARRAYS];   // Freed array numbers
  logic [`HEAP_COUNT_BITS-1:0]   freeTop;                    // Entries on stack
  logic [`HEAP_COUNT_BITS-1:0]   allocCount;                 // High-water mark
  logic [`HEAP_ARRAYS-1:0]       live;                       // One flag per array
  logic [`HEAP_ADDRESS_BITS-1:0] topIndex;                   // Slot of stack top
  logic                          stackEmpty;

  // --------------------------------------------------
  // Status for the addressed array
  // --------------------------------------------------
  assign stackEmpty    = (freeTop == '0);
  assign topIndex      = freeTop[`HEAP_ADDRESS_BITS-1:0] - 1'b1;
  assign arrayLive     = live[array];
  assign everAllocated = ({1'b0, array} < allocCount);      // Handed out at some point
  assign canAllocate   = !stackEmpty || (allocCount < `HEAP_ARRAYS);
  assign nextHandle    = stackEmpty ? allocCount[`HEAP_ADDRESS_BITS-1:0]
                                    : freeStack[topIndex];   // Reuse last freed first

  // --------------------------------------------------
  // Control state
  // --------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      freeTop    <= '0;
      allocCount <= '0;
      live       <= '0;
    end else if (clearAll) begin                         // Heap reset action
      freeTop    <= '0;
      allocCount <= '0;
      live       <= '0;
    end else if (allocate) begin
      if (stackEmpty) allocCount <= allocCount + 1'b1;   // Fresh array
      else            freeTop    <= freeTop - 1'b1;      // Pop freed array
      live[nextHandle] <= 1'b1;
    end else if (free) begin
      freeTop     <= freeTop + 1'b1;
      live[array] <= 1'b0;
    end
  end

  // Stack payload
  always_ff @(posedge clock) begin
    if (free) freeStack[freeTop[`HEAP_ADDRESS_BITS-1:0]] <= array;
  end

  // Control only frees live arrays so the stack cannot fill past the count
  assert property (@(posedge clock) disable iff (!resetN)
                   free |-> freeTop < `HEAP_ARRAYS)
    else $error("Free stack overflow");

  assert property (@(posedge clock) disable iff (!resetN)
                   allocate |-> canAllocate)
    else $error("Allocate strobe with no array available");

endmodule

`default_nettype wire

/* src/heapPkg.sv */
//--------------------------------------------------
// Heap package
// Command, error and internal codes, result word
//--------------------------------------------------
`default_nettype none
`include "heap_macros.svh"

package heapPkg;

  typedef enum logic [7:0] {
    actIdle = 8'd0,  actReset = 8'd1,  actWrite = 8'd2,  actRead = 8'd3,
    actSize = 8'd4,  actInc = 8'd5,    actDec = 8'd6,    actPush = 8'd14,
    actPop = 8'd15,  actAlloc = 8'd18, actFree = 8'd19,  actAdd = 8'd20,
    actAddAfter = 8'd21, actSubtract = 8'd22, actSubAfter = 8'd23,
    actShiftLeft = 8'd24, actShiftRight = 8'd25, actNotLogical = 8'd26,
    actNot = 8'd27,  actOr = 8'd28,    actXor = 8'd29,   actAnd = 8'd30
  } heapActionT;                                      // Reference numbering kept

  typedef enum logic [2:0] {
    errNone, errNeverAllocated, errFreed, errOutOfBounds,
    errEmpty, errFull, errOutOfMemory
  } heapErrorT;

  typedef enum logic [2:0] {
    sizeHold, sizeClearAll, sizeClearHandle, sizeInc, sizeDec, sizeGrowTo
  } heapSizeOpT;                                      // Size table commands

  typedef enum logic [3:0] {
    updPass, updAdd, updSub, updShiftLeft, updShiftRight,
    updNotLogical, updNot, updOr, updXor, updAnd
  } heapUpdateT;                                      // Element ALU select

  // Result word holds an element value or an allocated handle
  typedef union packed {
    logic [`HEAP_DATA_BITS-1:0] element;
    struct packed {
      logic [`HEAP_DATA_BITS-`HEAP_ADDRESS_BITS-1:0] pad;   // Always zero
      logic [`HEAP_ADDRESS_BITS-1:0]                 handle;
    } handleView;
  } heapWordT;

endpackage

`default_nettype wire

/* src/heap_macros.svh */
//--------------------------------------------------
// Heap sizing
// Widths of array numbers, indices and elements
//--------------------------------------------------
`ifndef HEAP_MACROS_SVH
`define HEAP_MACROS_SVH

// --------------------------------------------------
// Base widths
// --------------------------------------------------
`define HEAP_ADDRESS_BITS 2                           // Bits in an array number
`define HEAP_INDEX_BITS   3                           // Bits in an element index
`define HEAP_DATA_BITS    16                          // Element width

// --------------------------------------------------
// Derived counts
// --------------------------------------------------
`define HEAP_ARRAY_LENGTH (1 << `HEAP_INDEX_BITS)     // Elements per array
`define HEAP_ARRAYS       (1 << `HEAP_ADDRESS_BITS)   // Number of arrays
`define HEAP_SIZE_BITS    (`HEAP_INDEX_BITS + 1)      // Holds 0 to array length
`define HEAP_COUNT_BITS   (`HEAP_ADDRESS_BITS + 1)    // Holds 0 to array count

`endif
